//--- bench/lsuTb.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsuTb;
    logic        clk;
    logic        rst;
    logic        stValid;
    logic [7:0]  stSqN;
    logic [7:0]  stStoreSqN;
    logic [31:0] stAddr;
    logic [31:0] stData;
    logic [3:0]  stWmask;
    logic        stFault;
    logic        ldValid;
    logic [7:0]  ldSqN;
    logic [31:0] ldAddr;
    logic [1:0]  ldSize;
    logic [7:0]  curSqN;
    logic        brTaken;
    logic [7:0]  brSqN;
    logic        brFlush;
    logic [7:0]  brStoreSqN;
    logic        ldResultValid;
    logic [31:0] ldResult;
    logic        sqEmpty;
    logic        sqDone;
    logic        sqFlushing;
    logic [7:0]  maxStoreSqN;

    // Memory image after all committed stores
    logic [7:0] model [`RAM_WORDS*4];
    int cycles;
    logic [7:0] seq;
    logic [7:0] nextStoreSqN;
    // Uncommitted stores in the queue in age order
    int pWord [$];
    logic [31:0] pData [$];
    logic [3:0] pMask [$];
    logic [7:0] pSqN [$];

    lsuTop lsuTop_inst (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 2000)
            reportFail("timeout, run exceeded 2000 cycles");
    end

    task automatic reportFail(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else
            reportFail($sformatf("mismatch at %0t: %s got %h expected %h",
                                 $time, name, got, exp));
    endtask

    function automatic logic [31:0] modelWord(input int w);
        return {model[4*w+3], model[4*w+2], model[4*w+1], model[4*w]};
    endfunction

    function automatic logic [31:0] overlay(input logic [31:0] base, input logic [31:0] data,
                                            input logic [3:0] mask);
        logic [31:0] r;
        r = base;
        for (int b = 0; b < 4; b++)
            if (mask[b])
                r[8*b +: 8] = data[8*b +: 8];
        return r;
    endfunction

    // Keep only the bytes that the access reads
    function automatic logic [31:0] maskLoad(input logic [31:0] val, input logic [1:0] off,
                                             input logic [1:0] size);
        logic [31:0] r;
        r = val;
        for (int b = 0; b < 4; b++) begin
            if (size == 2'd0 && b != off)
                r[8*b +: 8] = 8'h00;
            if (size == 2'd1 && (b / 2) != off[1])
                r[8*b +: 8] = 8'h00;
        end
        return r;
    endfunction

    task automatic storeOp(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] mask, input logic fault);
        @(negedge clk);
        stValid = 1'b1;
        stSqN = seq;
        stStoreSqN = nextStoreSqN;
        stAddr = addr;
        stData = data;
        stWmask = mask;
        stFault = fault;
        if (!fault) begin
            pWord.push_back(addr[9:2]);
            pData.push_back(data);
            pMask.push_back(mask);
            pSqN.push_back(seq);
            nextStoreSqN++;
        end
        seq++;
        @(negedge clk);
        stValid = 1'b0;
        stFault = 1'b0;
    endtask

    task automatic commitUpTo(input logic [7:0] sqn);
        @(negedge clk);
        curSqN = sqn;
        while (pSqN.size() > 0 && $signed(sqn - pSqN[0]) > 0) begin
            for (int b = 0; b < 4; b++)
                if (pMask[0][b])
                    model[4*pWord[0]+b] = pData[0][8*b +: 8];
            void'(pWord.pop_front());
            void'(pData.pop_front());
            void'(pMask.pop_front());
            void'(pSqN.pop_front());
        end
    endtask

    task automatic waitDone();
        int n;
        n = 0;
        @(negedge clk);
        while (!sqDone) begin
            @(negedge clk);
            n++;
            if (n > 300)
                reportFail("store queue did not drain, sqDone stayed low");
        end
    endtask

    task automatic loadCheck(input logic [31:0] addr, input logic [1:0] size,
                             input logic [7:0] sqn, input logic [31:0] exp);
        int issued;
        @(negedge clk);
        ldValid = 1'b1;
        ldAddr = addr;
        ldSize = size;
        ldSqN = sqn;
        issued = cycles;
        @(negedge clk);
        ldValid = 1'b0;
        while (!ldResultValid) begin
            @(negedge clk);
            if (cycles - issued > 10)
                reportFail("load result never became valid");
        end
        checkEq("ldLatency", cycles - issued, 3);
        checkEq("ldResult", ldResult, exp);
    endtask

    task automatic resetState();
        checkEq("sqEmpty", sqEmpty, 1);
        checkEq("sqDone", sqDone, 1);
        checkEq("ldResultValid", ldResultValid, 0);
        checkEq("sqFlushing", sqFlushing, 0);
        checkEq("maxStoreSqN", maxStoreSqN, 7);
    endtask

    task automatic forwardUncommitted();
        logic [31:0] a;
        logic [31:0] b;
        logic [7:0] older;
        older = seq - 1;
        a = $urandom;
        b = $urandom;
        storeOp(32'h20, a, 4'b0011, 1'b0);
        storeOp(32'h20, b, 4'b0110, 1'b0);
        loadCheck(32'h20, 2'd2, seq, overlay(overlay(modelWord(8), a, 4'b0011), b, 4'b0110));
        loadCheck(32'h21, 2'd0, seq, maskLoad(overlay(modelWord(8), b, 4'b0110), 2'd1, 2'd0));
        loadCheck(32'h20, 2'd2, older, modelWord(8));
    endtask

    task automatic commitAndDrain();
        int words [6] = '{16, 17, 18, 16, 19, 17};
        for (int i = 0; i < 6; i++)
            storeOp(words[i] * 4, $urandom, 4'b1111, 1'b0);
        commitUpTo(seq);
        waitDone();
        loadCheck(32'h20, 2'd2, seq, modelWord(8));
        for (int w = 16; w < 20; w++)
            loadCheck(w * 4, 2'd2, seq, modelWord(w));
        loadCheck(32'h46, 2'd1, seq, maskLoad(modelWord(17), 2'd2, 2'd1));
    endtask

    task automatic arbitration();
        logic [31:0] expQ [$];
        int issueQ [$];
        for (int w = 48; w < 52; w++)
            storeOp(w * 4, $urandom, 4'b1111, 1'b0);
        commitUpTo(seq);
        fork
            begin
                for (int i = 0; i < 20; i++) begin
                    @(negedge clk);
                    ldValid = 1'b1;
                    ldAddr = (16 + i % 4) * 4;
                    ldSize = 2'd2;
                    ldSqN = seq;
                    expQ.push_back(modelWord(16 + i % 4));
                    issueQ.push_back(cycles);
                end
                @(negedge clk);
                ldValid = 1'b0;
            end
            begin
                int got;
                got = 0;
                while (got < 20) begin
                    @(negedge clk);
                    if (ldResultValid) begin
                        checkEq("ldLatency", cycles - issueQ.pop_front(), 3);
                        checkEq("ldResult", ldResult, expQ.pop_front());
                        got++;
                    end
                end
            end
        join
        waitDone();
        for (int w = 48; w < 52; w++)
            loadCheck(w * 4, 2'd2, seq, modelWord(w));
    endtask

    task automatic branchInvalidate();
        logic [7:0] s0;
        logic [7:0] q0;
        s0 = seq;
        q0 = nextStoreSqN;
        for (int w = 32; w < 36; w++)
            storeOp(w * 4, $urandom, 4'b1111, 1'b0);
        storeOp(36 * 4, $urandom, 4'b1111, 1'b1);
        commitUpTo(s0 + 2);
        brTaken = 1'b1;
        brSqN = s0 + 1;
        brFlush = 1'b0;
        brStoreSqN = q0 + 1;
        @(negedge clk);
        brTaken = 1'b0;
        // Younger stores are dropped and their queue slots get reused
        pWord.delete();
        pData.delete();
        pMask.delete();
        pSqN.delete();
        nextStoreSqN = q0 + 2;
        waitDone();
        for (int w = 32; w < 37; w++)
            loadCheck(w * 4, 2'd2, seq, modelWord(w));
    endtask

    task automatic mmioStore();
        logic [31:0] v;
        storeOp(32'h100, $urandom, 4'b1111, 1'b0);
        commitUpTo(seq);
        waitDone();
        v = $urandom;
        storeOp(32'h8000_0100, v, 4'b1111, 1'b0);
        loadCheck(32'h8000_0100, 2'd2, seq, modelWord(64));
        commitUpTo(seq);
        waitDone();
        loadCheck(32'h8000_0100, 2'd2, seq, v);
    endtask

    initial begin
        void'($urandom(32'hb30b016c));
        for (int i = 0; i < `RAM_WORDS * 4; i++)
            model[i] = 8'h00;
        clk = 1'b0;
        rst = 1'b1;
        cycles = 0;
        seq = 8'd1;
        nextStoreSqN = 8'd0;
        stValid = 1'b0;
        stSqN = '0;
        stStoreSqN = '0;
        stAddr = '0;
        stData = '0;
        stWmask = '0;
        stFault = 1'b0;
        ldValid = 1'b0;
        ldSqN = '0;
        ldAddr = '0;
        ldSize = 2'd2;
        curSqN = '0;
        brTaken = 1'b0;
        brSqN = '0;
        brFlush = 1'b0;
        brStoreSqN = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        resetState();
        forwardUncommitted();
        commitAndDrain();
        arbitration();
        branchInvalidate();
        mmioStore();
        checkEq("sqEmpty", sqEmpty, 1);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+hw
hw/coreTypesPkg.sv
hw/memTypesPkg.sv
hw/memPortIf.sv
hw/dataRam.sv
hw/memArbiter.sv
hw/loadUnit.sv
hw/storeQueue.sv
hw/lsuTop.sv
bench/lsuTb.sv

//--- hw/coreTypesPkg.sv
package coreTypesPkg;

    // Wrapping sequence number, compare via signed difference
    typedef logic [7:0] SqN;

    // Store after address generation
    typedef struct packed {
        logic        valid;
        SqN          sqN;
        SqN          storeSqN;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  wmask;
        logic        fault;
    } AGU_UOp;

    // Load request, size 0 byte, 1 half, 2 word
    typedef struct packed {
        logic        valid;
        SqN          sqN;
        logic [31:0] addr;
        logic [1:0]  size;
    } LD_UOp;

    // Mispredict information
    typedef struct packed {
        logic taken;
        SqN   sqN;
        logic flush;
        SqN   storeSqN;
    } BranchProv;

endpackage

//--- hw/dataRam.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module dataRam #(
    parameter int DEPTH = `RAM_WORDS,
    parameter int ADDR_W = $clog2(DEPTH)
) (
    input  logic              clk,
    input  logic              we,
    input  logic [ADDR_W-1:0] addr,
    input  logic [31:0]       wdata,
    input  logic [3:0]        wmask,
    output logic [31:0]       rdata
);
    logic [31:0] mem [DEPTH];

    initial begin
        for (int i = 0; i < DEPTH; i++)
            mem[i] = '0;
    end

    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < 4; b++) begin
                if (wmask[b])
                    mem[addr][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
        // Read returns the old word
        rdata <= mem[addr];
    end

endmodule

//--- hw/loadUnit.sv
`timescale 1ns/1ps

module loadUnit
    import coreTypesPkg::*;
    import memTypesPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  LD_UOp       uopLd,
    input  StFwdResult  fwd,
    output logic [31:0] result,
    output logic        resultValid,
    memPortIf.requester port
);
    LD_UOp s1;
    logic s2Valid;
    logic [1:0] s2Size;
    logic [1:0] s2Off;
    logic [3:0] accMask;
    logic [31:0] merged;

    // Read request goes out in the cycle after the load is sampled
    assign port.req = s1.valid;
    assign port.write = 1'b0;
    assign port.addr = s1.addr;
    assign port.wdata = '0;
    assign port.wmask = '0;

    always_comb begin
        case (s2Size)
            2'd0: accMask = 4'b0001 << s2Off;
            2'd1: accMask = s2Off[1] ? 4'b1100 : 4'b0011;
            default: accMask = 4'b1111;
        endcase
        for (int b = 0; b < 4; b++) begin
            if (fwd.valid && fwd.mask[b])
                merged[8*b +: 8] = fwd.data[8*b +: 8];
            else
                merged[8*b +: 8] = port.rdata[8*b +: 8];
            // Unread bytes stay zero
            if (!accMask[b])
                merged[8*b +: 8] = 8'h00;
        end
    end

    always_ff @(posedge clk) begin
        s1 <= uopLd;
        s2Size <= s1.size;
        s2Off <= s1.addr[1:0];
        result <= merged;
        if (rst) begin
            s1.valid <= 1'b0;
            s2Valid <= 1'b0;
            resultValid <= 1'b0;
        end else begin
            s2Valid <= s1.valid && port.grant;
            resultValid <= s2Valid;
        end
    end

endmodule

//--- hw/lsuTop.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsuTop
    import coreTypesPkg::*;
    import memTypesPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        stValid,
    input  SqN          stSqN,
    input  SqN          stStoreSqN,
    input  logic [31:0] stAddr,
    input  logic [31:0] stData,
    input  logic [3:0]  stWmask,
    input  logic        stFault,
    input  logic        ldValid,
    input  SqN          ldSqN,
    input  logic [31:0] ldAddr,
    input  logic [1:0]  ldSize,
    input  SqN          curSqN,
    input  logic        brTaken,
    input  SqN          brSqN,
    input  logic        brFlush,
    input  SqN          brStoreSqN,
    output logic        ldResultValid,
    output logic [31:0] ldResult,
    output logic        sqEmpty,
    output logic        sqDone,
    output logic        sqFlushing,
    output SqN          maxStoreSqN
);
    AGU_UOp uopSt;
    LD_UOp uopLd;
    BranchProv branch;
    ST_Ack stAck;
    StFwdResult fwd;
    logic ramWe;
    logic [$clog2(`RAM_WORDS)-1:0] ramAddr;
    logic [31:0] ramWdata;
    logic [3:0] ramWmask;
    logic [31:0] ramRdata;

    memPortIf ldPort ();
    memPortIf stPort ();

    assign uopSt = '{valid: stValid, sqN: stSqN, storeSqN: stStoreSqN, addr: stAddr,
                     data: stData, wmask: stWmask, fault: stFault};
    assign uopLd = '{valid: ldValid, sqN: ldSqN, addr: ldAddr, size: ldSize};
    assign branch = '{taken: brTaken, sqN: brSqN, flush: brFlush, storeSqN: brStoreSqN};

    storeQueue storeQueue_inst (
        .clk         (clk),
        .rst         (rst),
        .uopSt       (uopSt),
        .uopLd       (uopLd),
        .curSqN      (curSqN),
        .branch      (branch),
        .stAck       (stAck),
        .empty       (sqEmpty),
        .done        (sqDone),
        .flushing    (sqFlushing),
        .maxStoreSqN (maxStoreSqN),
        .fwd         (fwd),
        .port        (stPort.requester)
    );

    loadUnit loadUnit_inst (
        .clk         (clk),
        .rst         (rst),
        .uopLd       (uopLd),
        .fwd         (fwd),
        .result      (ldResult),
        .resultValid (ldResultValid),
        .port        (ldPort.requester)
    );

    memArbiter memArbiter_inst (
        .clk      (clk),
        .rst      (rst),
        .ramRdata (ramRdata),
        .stAck    (stAck),
        .ramWe    (ramWe),
        .ramAddr  (ramAddr),
        .ramWdata (ramWdata),
        .ramWmask (ramWmask),
        .ldPort   (ldPort.arbiter),
        .stPort   (stPort.arbiter)
    );

    dataRam dataRam_inst (
        .clk   (clk),
        .we    (ramWe),
        .addr  (ramAddr),
        .wdata (ramWdata),
        .wmask (ramWmask),
        .rdata (ramRdata)
    );

endmodule

//--- hw/lsu_config.svh
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// Store queue entries
`define SQ_SIZE 8

// Drained stores awaiting a memory acknowledgement
`define SQ_EVICTED 4

// Data RAM depth in 32-bit words
`define RAM_WORDS 256

// Word address bit 29 selects the MMIO region
`define IS_MMIO_PMA_W(addr) (addr[29])

`endif

//--- hw/memArbiter.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module memArbiter
    import memTypesPkg::*;
#(
    parameter int ADDR_W = $clog2(`RAM_WORDS)
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [31:0]       ramRdata,
    output ST_Ack             stAck,
    output logic              ramWe,
    output logic [ADDR_W-1:0] ramAddr,
    output logic [31:0]       ramWdata,
    output logic [3:0]        ramWmask,
    memPortIf.arbiter         ldPort,
    memPortIf.arbiter         stPort
);
    logic stGrant;

    // Loads always win
    assign stGrant = stPort.req && !ldPort.req;
    assign ldPort.grant = ldPort.req;
    assign stPort.grant = stGrant;

    assign ramWe = ldPort.req ? ldPort.write : (stGrant && stPort.write);
    assign ramAddr = ldPort.req ? ldPort.addr[ADDR_W+1:2] : stPort.addr[ADDR_W+1:2];
    assign ramWdata = ldPort.req ? ldPort.wdata : stPort.wdata;
    assign ramWmask = ldPort.req ? ldPort.wmask : stPort.wmask;

    assign ldPort.rdata = ramRdata;
    assign stPort.rdata = ramRdata;

    // Store slot id rides in the low address bits
    always_ff @(posedge clk) begin
        stAck.id <= StID_t'(stPort.addr[1:0]);
        stAck.fail <= !stGrant;
        if (rst)
            stAck.valid <= 1'b0;
        else
            stAck.valid <= stPort.req;
    end

endmodule

//--- hw/memPortIf.sv
`timescale 1ns/1ps

interface memPortIf;
    logic        req;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wmask;
    // Same-cycle grant from the arbiter
    logic        grant;
    logic [31:0] rdata;

    modport requester (
        output req, write, addr, wdata, wmask,
        input  grant, rdata
    );

    modport arbiter (
        input  req, write, addr, wdata, wmask,
        output grant, rdata
    );
endinterface

//--- hw/memTypesPkg.sv
package memTypesPkg;

    // Eviction slot id
    typedef logic [1:0] StID_t;

    // Store sent to the memory side
    typedef struct packed {
        logic        valid;
        StID_t       id;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  wmask;
        logic        isMMIO;
    } ST_UOp;

    // Memory side answer for one issued store
    typedef struct packed {
        logic  valid;
        StID_t id;
        logic  fail;
    } ST_Ack;

    // Store-to-load forwarding result
    // A set mask bit means the byte is supplied or not needed
    typedef struct packed {
        logic        valid;
        logic [31:0] data;
        logic [3:0]  mask;
    } StFwdResult;

endpackage

//--- hw/storeQueue.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module storeQueue
    import coreTypesPkg::*;
    import memTypesPkg::*;
#(
    parameter int NUM_ENTRIES = `SQ_SIZE,
    parameter int NUM_EVICTED = `SQ_EVICTED
) (
    input  logic       clk,
    input  logic       rst,
    input  AGU_UOp     uopSt,
    input  LD_UOp      uopLd,
    input  SqN         curSqN,
    input  BranchProv  branch,
    input  ST_Ack      stAck,
    output logic       empty,
    output logic       done,
    output logic       flushing,
    output SqN         maxStoreSqN,
    output StFwdResult fwd,
    memPortIf.requester port
);
    localparam int IDXW = $clog2(NUM_ENTRIES);
    localparam int EVW = $clog2(NUM_EVICTED);

    typedef struct packed {
        logic        valid;
        logic        ready;
        SqN          sqN;
        logic [29:0] addr;
        logic [31:0] data;
        logic [3:0]  wmask;
    } SqEntry;

    typedef struct packed {
        ST_UOp st;
        logic  issued;
    } EvEntry;

    SqEntry entries [NUM_ENTRIES];
    EvEntry evicted [NUM_EVICTED];
    SqN baseIndex;
    logic [EVW:0] evictedIn;
    logic [NUM_EVICTED-1:0] usedIds;
    ST_Ack stAckR;
    ST_UOp issue;
    LD_UOp ldR;

    logic allInvalid;
    logic allowDequeue;
    logic [3:0] lookupMask;
    logic [31:0] lookupData;
    logic [29:0] ldWord;
    StID_t nextId;
    logic nextIdValid;
    logic [EVW-1:0] ackIdx;

    // Stores are word aligned, the low address bits carry the slot id
    assign port.req = issue.valid;
    assign port.write = 1'b1;
    assign port.addr = {issue.addr[31:2], issue.id};
    assign port.wdata = issue.data;
    assign port.wmask = issue.wmask;

    assign ldWord = ldR.addr[31:2];

    always_comb begin
        allInvalid = 1'b1;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (entries[i].valid)
                allInvalid = 1'b0;
        end
    end

    // Bytes outside the load access count as supplied
    always_comb begin
        case (ldR.size)
            2'd0: lookupMask = ~(4'b0001 << ldR.addr[1:0]);
            2'd1: lookupMask = ldR.addr[1] ? 4'b0011 : 4'b1100;
            default: lookupMask = 4'b0000;
        endcase
        lookupData = '0;

        // Evicted stores are older than anything still queued
        for (int i = 0; i < NUM_EVICTED; i++) begin
            if (evicted[i].st.valid && !evicted[i].st.isMMIO &&
                evicted[i].st.addr[31:2] == ldWord) begin
                for (int b = 0; b < 4; b++) begin
                    if (evicted[i].st.wmask[b])
                        lookupData[8*b +: 8] = evicted[i].st.data[8*b +: 8];
                end
                lookupMask = lookupMask | evicted[i].st.wmask;
            end
        end

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (entries[i].valid && entries[i].addr == ldWord &&
                ($signed(entries[i].sqN - ldR.sqN) < 0 || entries[i].ready) &&
                !`IS_MMIO_PMA_W(entries[i].addr)) begin
                for (int b = 0; b < 4; b++) begin
                    if (entries[i].wmask[b])
                        lookupData[8*b +: 8] = entries[i].data[8*b +: 8];
                end
                lookupMask = lookupMask | entries[i].wmask;
            end
        end
    end

    // An older store to the same word may still fail and come back, so wait for it
    always_comb begin
        allowDequeue = 1'b1;
        for (int i = 0; i < NUM_EVICTED; i++) begin
            if (evicted[i].st.valid &&
                (evicted[i].st.addr[31:2] == entries[0].addr ||
                 (evicted[i].st.isMMIO && `IS_MMIO_PMA_W(entries[0].addr))))
                allowDequeue = 1'b0;
        end
        if ((stAck.valid && stAck.fail) || (stAckR.valid && stAckR.fail))
            allowDequeue = 1'b0;
    end

    always_comb begin
        nextId = '0;
        nextIdValid = 1'b0;
        for (int i = NUM_EVICTED - 1; i >= 0; i--) begin
            if (!usedIds[i]) begin
                nextId = StID_t'(i);
                nextIdValid = 1'b1;
            end
        end
        // Slot freed this cycle can be handed out again right away
        if (stAckR.valid && !stAckR.fail) begin
            nextId = stAckR.id;
            nextIdValid = 1'b1;
        end
    end

    always_comb begin
        ackIdx = '0;
        for (int i = 0; i < NUM_EVICTED; i++) begin
            if (evicted[i].st.valid && evicted[i].st.id == stAckR.id)
                ackIdx = EVW'(i);
        end
    end

    assign done = (!entries[0].valid ||
                   (!entries[0].ready && $signed(curSqN - entries[0].sqN) <= 0)) &&
                  evictedIn == '0;

    always_ff @(posedge clk) begin
        stAckR <= stAck;
        ldR <= uopLd;
        fwd.valid <= ldR.valid;
        fwd.data <= lookupData;
        fwd.mask <= lookupMask;
        if (rst) begin
            stAckR.valid <= 1'b0;
            ldR.valid <= 1'b0;
            fwd.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        logic [EVW:0] nextIn;
        SqN nextBase;
        logic doEnq;
        logic [IDXW-1:0] enqIdx;

        if (rst) begin
            for (int i = 0; i < NUM_ENTRIES; i++)
                entries[i].valid <= 1'b0;
            for (int i = 0; i < NUM_EVICTED; i++) begin
                evicted[i].st.valid <= 1'b0;
                evicted[i].issued <= 1'b0;
            end
            evictedIn <= '0;
            usedIds <= '0;
            baseIndex <= '0;
            maxStoreSqN <= SqN'(NUM_ENTRIES - 1);
            empty <= 1'b1;
            flushing <= 1'b0;
            issue.valid <= 1'b0;
        end else begin
            nextIn = evictedIn;
            nextBase = baseIndex;
            doEnq = 1'b0;
            issue.valid <= 1'b0;

            for (int i = 0; i < NUM_ENTRIES; i++) begin
                if ($signed(curSqN - entries[i].sqN) > 0)
                    entries[i].ready <= 1'b1;
            end

            if (stAckR.valid) begin
                if (!stAckR.fail) begin
                    for (int i = 0; i < NUM_EVICTED - 1; i++) begin
                        if (i >= ackIdx)
                            evicted[i] <= evicted[i+1];
                    end
                    evicted[NUM_EVICTED-1].st.valid <= 1'b0;
                    nextIn = nextIn - 1'b1;
                    usedIds[stAckR.id] <= 1'b0;
                end else begin
                    evicted[ackIdx].issued <= 1'b0;
                end
            end

            if (entries[0].valid && entries[0].ready && !branch.taken &&
                nextIdValid && allowDequeue) begin
                for (int i = 1; i < NUM_ENTRIES; i++) begin
                    entries[i-1] <= entries[i];
                    if ($signed(curSqN - entries[i].sqN) > 0)
                        entries[i-1].ready <= 1'b1;
                end
                entries[NUM_ENTRIES-1].valid <= 1'b0;
                if (!flushing)
                    nextBase = nextBase + 1'b1;

                issue.valid <= 1'b1;
                issue.id <= nextId;
                issue.addr <= {entries[0].addr, 2'b00};
                issue.data <= entries[0].data;
                issue.wmask <= entries[0].wmask;
                issue.isMMIO <= `IS_MMIO_PMA_W(entries[0].addr);

                evicted[nextIn[EVW-1:0]].st.valid <= 1'b1;
                evicted[nextIn[EVW-1:0]].st.id <= nextId;
                evicted[nextIn[EVW-1:0]].st.addr <= {entries[0].addr, 2'b00};
                evicted[nextIn[EVW-1:0]].st.data <= entries[0].data;
                evicted[nextIn[EVW-1:0]].st.wmask <= entries[0].wmask;
                evicted[nextIn[EVW-1:0]].st.isMMIO <= `IS_MMIO_PMA_W(entries[0].addr);
                evicted[nextIn[EVW-1:0]].issued <= 1'b1;
                nextIn = nextIn + 1'b1;
                usedIds[nextId] <= 1'b1;
            end else if (evicted[0].st.valid && !evicted[0].issued) begin
                // Retry after a failed acknowledgement
                issue <= evicted[0].st;
                evicted[0].issued <= 1'b1;
            end

            if (branch.taken) begin
                for (int i = 0; i < NUM_ENTRIES; i++) begin
                    if ($signed(entries[i].sqN - branch.sqN) > 0 && !entries[i].ready)
                        entries[i].valid <= 1'b0;
                end
                if (branch.flush)
                    nextBase = branch.storeSqN + 1'b1;
            end

            if (branch.taken && branch.flush)
                flushing <= 1'b1;
            else if (empty)
                flushing <= 1'b0;

            if (uopSt.valid && !uopSt.fault &&
                (!branch.taken || $signed(uopSt.sqN - branch.sqN) <= 0)) begin
                enqIdx = uopSt.storeSqN[IDXW-1:0] - nextBase[IDXW-1:0];
                entries[enqIdx].valid <= 1'b1;
                entries[enqIdx].ready <= 1'b0;
                entries[enqIdx].sqN <= uopSt.sqN;
                entries[enqIdx].addr <= uopSt.addr[31:2];
                entries[enqIdx].data <= uopSt.data;
                entries[enqIdx].wmask <= uopSt.wmask;
                doEnq = 1'b1;
            end

            empty <= allInvalid && !doEnq;
            baseIndex <= nextBase;
            maxStoreSqN <= nextBase + SqN'(NUM_ENTRIES - 1);
            evictedIn <= nextIn;
        end
    end

endmodule
